//--- vga_overlay.f
verilog/overlay_geom_pkg.sv
verilog/overlay_pixel_pkg.sv
verilog/screen_region_decoder.sv
verilog/camera_overlay.sv
verilog/pixel_compositor.sv
verilog/vga_overlay_top.sv
sim/vga_overlay_chk.sv
sim/vga_overlay_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the vga_overlay testbench with verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

top=vga_overlay_tb
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -f vga_overlay.f -o "$top"

# tee keeps the log even when the simulation stops early
./obj_dir/"$top" | tee "$log"

if grep -qx "No errors" "$log"; then
  echo "simulation passed"
else
  echo "simulation failed, see $log"
  exit 1
fi

//--- sim/vga_overlay_tb.sv
module vga_overlay_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 4;
  localparam int num_cams = overlay_geom_pkg::num_cams;
  localparam int addr_w = overlay_geom_pkg::addr_w;
  localparam int img_w = overlay_geom_pkg::img_cols;
  localparam int img_h = overlay_geom_pkg::img_rows;
  localparam int fbox_row = overlay_geom_pkg::fbox_row_min;
  localparam int fb_depth = 256;     // buffer model wraps on the low address bits
  localparam int sweep_cols = 432;   // covers both images and their bars
  // cycles driven by each test
  localparam int cyc_reset = 16;
  localparam int cyc_image = 96;
  localparam int cyc_addr = sweep_cols + 4;
  localparam int cyc_prox = 40;
  localparam int cyc_centroid = 256;
  localparam int cyc_fbox = sweep_cols + 64;
  localparam int total_cycles = cyc_reset + cyc_image + cyc_addr + cyc_prox +
                                cyc_centroid + cyc_fbox;

  logic rst;  // pixel clock
  logic clk;  // reset
  logic visible;
  logic new_pxl;
  logic rgbmode;
  logic [overlay_geom_pkg::pos_w-1:0] col;
  logic [overlay_geom_pkg::pos_w-1:0] row;
  overlay_pixel_pkg::cam_status_t [num_cams-1:0] cam_status;
  overlay_pixel_pkg::buf_pixel_t  [num_cams-1:0] frame_pixel;
  logic [num_cams-1:0][addr_w-1:0] frame_addr;
  overlay_pixel_pkg::vga_rgb_t vga;

  overlay_pixel_pkg::buf_pixel_t fb_mem [num_cams][fb_depth];
  overlay_pixel_pkg::cam_status_t cur_status [num_cams];  // applied with the next step
  logic cur_rgbmode;

  // reference state
  logic [addr_w-1:0] model_addr [num_cams];
  int prev_col;
  int prev_row;
  logic prev_npx;
  overlay_pixel_pkg::vga_rgb_t exp_vga;
  int rgb_errors;
  int addr_errors;

  vga_overlay_top dut_i (
    .rst         (rst),
    .clk         (clk),
    .visible     (visible),
    .new_pxl     (new_pxl),
    .rgbmode     (rgbmode),
    .col         (col),
    .row         (row),
    .cam_status  (cam_status),
    .frame_pixel (frame_pixel),
    .frame_addr  (frame_addr),
    .vga         (vga)
  );

  initial begin
    rst = 1'b0;
    forever #(clk_period / 2) rst = ~rst;
  end

  initial begin
    #(2 * total_cycles * clk_period);
    $display("timeout: the tests did not finish within %0d cycles", 2 * total_cycles);
    $display("Errors found");
    $finish;
  end

  function automatic int cam_origin(input int cam);
    return (cam == 0) ? int'(overlay_geom_pkg::cam_col_origin[0]) :
                        int'(overlay_geom_pkg::cam_col_origin[1]);
  endfunction

  function automatic int box_origin(input int cam);
    return (cam == 0) ? int'(overlay_geom_pkg::fbox_col_origin[0]) :
                        int'(overlay_geom_pkg::fbox_col_origin[1]);
  endfunction

  function automatic bit in_image(input int cam, input int c, input int r);
    int lc;
    lc = c - cam_origin(cam);
    return (r < img_h) && (lc >= 0) && (lc < img_w);
  endfunction

  function automatic overlay_pixel_pkg::vga_rgb_t expand_filter(input logic [2:0] f);
    overlay_pixel_pkg::vga_rgb_t res;
    res.red   = f[2] ? 4'hf : 4'h0;
    res.green = f[1] ? 4'hf : 4'h0;
    res.blue  = f[0] ? 4'hf : 4'h0;
    return res;
  endfunction

  function automatic overlay_pixel_pkg::cam_status_t random_status();
    return overlay_pixel_pkg::cam_status_t'($urandom);
  endfunction

  // expected colour of one camera channel at a raster position
  function automatic overlay_pixel_pkg::vga_rgb_t expect_cam_color(
    input int cam, input int c, input int r, input overlay_pixel_pkg::cam_status_t st,
    input overlay_pixel_pkg::buf_pixel_t pix, input logic mode);
    int lc;
    logic [2:0] seg;
    overlay_pixel_pkg::vga_rgb_t res;
    lc = c - cam_origin(cam);
    res = overlay_pixel_pkg::black;
    if (in_image(cam, c, r)) begin
      if (mode) res = {pix.red, pix.green, pix.blue};
      else res = {pix.green, pix.green, pix.green};  // grey byte bits 7:4
    end else if ((r < img_h) && (lc >= img_w) && (lc < img_w + 8)) begin
      if (7 - int'(st.proximity) <= (r / 16) % 8) res = expand_filter(st.rgbfilter);
    end else if ((r >= img_h) && (r < img_h + 8) && (lc >= 0) && (lc < img_w)) begin
      seg = 3'(lc / 20);
      if (st.centroid[seg]) res = expand_filter(st.rgbfilter);
    end else if ((r >= fbox_row) && (r < fbox_row + 8) &&
                 (c >= box_origin(cam)) && (c < box_origin(cam) + 8)) begin
      res = expand_filter(st.rgbfilter);
    end
    return res;
  endfunction

  task automatic check_rgb(input overlay_pixel_pkg::vga_rgb_t got,
                           input overlay_pixel_pkg::vga_rgb_t exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s, got %03h expected %03h", $time, what, got, exp);
      rgb_errors++;
    end
  endtask

  task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("error %0t: %s, got %0d expected %0d", $time, what, got, exp);
      addr_errors++;
    end
  endtask

  // one pixel cycle drives at the rising edge and checks the previous pixel at the falling edge
  task automatic step(input int c, input int r, input logic vis, input logic npx);
    overlay_pixel_pkg::buf_pixel_t pix [num_cams];
    overlay_pixel_pkg::vga_rgb_t next_exp;
    @(posedge rst);
    for (int cam = 0; cam < num_cams; cam++) begin
      if (prev_row >= img_h) model_addr[cam] = '0;
      else if (prev_npx && in_image(cam, prev_col, prev_row)) model_addr[cam] += 1'b1;
      pix[cam] = fb_mem[cam][model_addr[cam][7:0]];
    end
    col <= 10'(c);
    row <= 10'(r);
    visible <= vis;
    new_pxl <= npx;
    rgbmode <= cur_rgbmode;
    next_exp = overlay_pixel_pkg::black;
    for (int cam = 0; cam < num_cams; cam++) begin
      cam_status[cam] <= cur_status[cam];
      frame_pixel[cam] <= pix[cam];
      if (vis) next_exp = next_exp | expect_cam_color(cam, c, r, cur_status[cam], pix[cam],
                                                       cur_rgbmode);
    end
    @(negedge rst);
    check_rgb(vga, exp_vga, $sformatf("vga for col %0d row %0d", prev_col, prev_row));
    for (int cam = 0; cam < num_cams; cam++) begin
      check_addr(frame_addr[cam], model_addr[cam], $sformatf("frame_addr of camera %0d", cam));
    end
    exp_vga = next_exp;
    prev_col = c;
    prev_row = r;
    prev_npx = npx;
  endtask

  task automatic reset_test();
    @(negedge rst);
    check_rgb(vga, overlay_pixel_pkg::black, "vga after reset");
    for (int cam = 0; cam < num_cams; cam++) check_addr(frame_addr[cam], '0, "addr after reset");
    repeat (8) step(0, 200, 1'b0, 1'b0);
  endtask

  task automatic image_test();
    int cam;
    for (int m = 0; m < 2; m++) begin
      cur_rgbmode = (m == 0);  // rgb first, then grey
      for (int i = 0; i < cyc_image / 2; i++) begin
        cam = int'($urandom % 2);
        step(cam_origin(cam) + int'($urandom_range(159, 0)), int'($urandom_range(119, 0)),
             1'b1, 1'($urandom % 2));
      end
    end
  endtask

  task automatic address_test();
    int count [num_cams];
    int r;
    logic npx;
    step(0, img_h, 1'b1, 1'b0);  // clears both counters
    for (int cam = 0; cam < num_cams; cam++) count[cam] = 0;
    r = int'($urandom_range(119, 0));
    for (int c = 0; c < sweep_cols; c++) begin
      npx = 1'($urandom % 2);
      for (int cam = 0; cam < num_cams; cam++) if (npx && in_image(cam, c, r)) count[cam]++;
      step(c, r, 1'b1, npx);
    end
    step(0, r, 1'b0, 1'b0);  // last new_pxl lands here
    for (int cam = 0; cam < num_cams; cam++) begin
      check_addr(frame_addr[cam], addr_w'(count[cam]), "address after a row sweep");
    end
    step(0, img_h + 3, 1'b0, 1'b0);
    step(0, 0, 1'b0, 1'b0);
    for (int cam = 0; cam < num_cams; cam++) check_addr(frame_addr[cam], '0, "address past image");
  endtask

  task automatic proximity_test();
    int cam;
    for (int i = 0; i < cyc_prox; i++) begin
      cam = int'($urandom % 2);
      cur_status[cam] = random_status();
      step(cam_origin(cam) + img_w + int'($urandom_range(7, 0)), int'($urandom_range(119, 0)),
           1'b1, 1'b0);
    end
  endtask

  task automatic centroid_test();
    int r;
    for (int i = 0; i < cyc_centroid / 16; i++) begin
      for (int cam = 0; cam < num_cams; cam++) cur_status[cam] = random_status();
      r = img_h + int'($urandom_range(7, 0));
      for (int cam = 0; cam < num_cams; cam++) begin
        for (int seg = 0; seg < 8; seg++) begin
          step(cam_origin(cam) + seg * 20 + int'($urandom_range(19, 0)), r, 1'b1, 1'b0);
        end
      end
    end
  endtask

  task automatic filterbox_blank_test();
    int r;
    for (int cam = 0; cam < num_cams; cam++) cur_status[cam] = random_status();
    r = fbox_row + int'($urandom_range(7, 0));
    for (int c = 0; c < sweep_cols; c++) step(c, r, 1'b1, 1'($urandom % 2));
    // blanking anywhere on the screen
    for (int i = 0; i < 64; i++) begin
      cur_rgbmode = 1'($urandom % 2);
      step(int'($urandom_range(639, 0)), int'($urandom_range(479, 0)), 1'b0, 1'($urandom % 2));
    end
  endtask

  initial begin
    void'($urandom(32'h4587));
    clk = 1'b1;
    visible = 1'b1;  // inputs during reset would light vga and step the counters
    new_pxl = 1'b1;
    rgbmode = 1'b1;
    col = 10'd5;
    row = 10'd5;
    cam_status = '0;
    frame_pixel = '1;
    cur_rgbmode = 1'b1;
    for (int cam = 0; cam < num_cams; cam++) begin
      cur_status[cam] = '0;
      model_addr[cam] = '0;
      for (int a = 0; a < fb_depth; a++) begin
        fb_mem[cam][a] = overlay_pixel_pkg::buf_pixel_t'($urandom);
      end
    end
    prev_col = 0;
    prev_row = 200;
    prev_npx = 1'b0;
    exp_vga = overlay_pixel_pkg::black;
    rgb_errors = 0;
    addr_errors = 0;
    repeat (5) @(posedge rst);
    clk <= 1'b0;
    visible <= 1'b0;
    new_pxl <= 1'b0;
    col <= '0;
    row <= 10'd200;  // counters stay cleared outside the image
    frame_pixel <= '0;
    reset_test();
    image_test();
    address_test();
    proximity_test();
    centroid_test();
    filterbox_blank_test();
    $display("checks done: %0d vga errors, %0d address errors", rgb_errors, addr_errors);
    if (rgb_errors + addr_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sim/vga_overlay_chk.sv
module vga_overlay_chk (
  input logic                                                                 rst,  // pixel clock
  input logic                                                                 clk,  // reset
  input logic                                                                 visible,
  input logic [overlay_geom_pkg::num_cams-1:0][overlay_geom_pkg::addr_w-1:0] frame_addr,
  input overlay_pixel_pkg::vga_rgb_t                                          vga
);
  timeunit 1ns;
  timeprecision 100ps;

  // counters and output stay cleared while reset is held
  assert property (@(posedge rst) (clk && $past(clk)) |->
                   ((frame_addr == '0) && (vga == overlay_pixel_pkg::black)))
    else $error("outputs not cleared during reset");

  // blanking reaches the output one cycle later
  assert property (@(posedge rst) disable iff (clk)
                   !visible |=> (vga == overlay_pixel_pkg::black))
    else $error("vga not black after visible was low");

  for (genvar c = 0; c < overlay_geom_pkg::num_cams; c++) begin : g_addr
    assert property (@(posedge rst) disable iff (clk)
                     (frame_addr[c] == $past(frame_addr[c])) ||
                     (frame_addr[c] == $past(frame_addr[c]) + 1'b1) ||
                     (frame_addr[c] == '0))
      else $error("frame_addr of camera %0d jumped", c);
  end

endmodule

bind vga_overlay_top vga_overlay_chk chk_i (
  .rst        (rst),
  .clk        (clk),
  .visible    (visible),
  .frame_addr (frame_addr),
  .vga        (vga)
);

//--- verilog/vga_overlay_top.sv
module vga_overlay_top (
  input  logic                                  rst,      // pixel clock
  input  logic                                  clk,      // async reset, active high
  input  logic                                  visible,
  input  logic                                  new_pxl,
  input  logic                                  rgbmode,
  input  logic [overlay_geom_pkg::pos_w-1:0]    col,
  input  logic [overlay_geom_pkg::pos_w-1:0]    row,
  input  overlay_pixel_pkg::cam_status_t [overlay_geom_pkg::num_cams-1:0] cam_status,
  input  overlay_pixel_pkg::buf_pixel_t  [overlay_geom_pkg::num_cams-1:0] frame_pixel,
  output logic [overlay_geom_pkg::num_cams-1:0][overlay_geom_pkg::addr_w-1:0] frame_addr,
  output overlay_pixel_pkg::vga_rgb_t           vga
);

  overlay_geom_pkg::cam_view_t   [overlay_geom_pkg::num_cams-1:0] view;
  overlay_pixel_pkg::vga_rgb_t   [overlay_geom_pkg::num_cams-1:0] cam_color;

  screen_region_decoder region_dec_i (
    .col  (col),
    .row  (row),
    .view (view)
  );

  // one channel per camera with index 0 on the left
  for (genvar c = 0; c < overlay_geom_pkg::num_cams; c++) begin : g_cam
    camera_overlay cam_i (
      .rst         (rst),
      .clk         (clk),
      .view        (view[c]),
      .status      (cam_status[c]),
      .frame_pixel (frame_pixel[c]),
      .rgbmode     (rgbmode),
      .new_pxl     (new_pxl),
      .frame_addr  (frame_addr[c]),
      .color       (cam_color[c])
    );
  end

  pixel_compositor compositor_i (
    .rst     (rst),
    .clk     (clk),
    .visible (visible),
    .color   (cam_color),
    .vga     (vga)
  );

endmodule

//--- verilog/pixel_compositor.sv
module pixel_compositor (
  input  logic                        rst,      // pixel clock
  input  logic                        clk,      // async reset, active high
  input  logic                        visible,
  input  overlay_pixel_pkg::vga_rgb_t [overlay_geom_pkg::num_cams-1:0] color,
  output overlay_pixel_pkg::vga_rgb_t vga
);

  overlay_pixel_pkg::vga_rgb_t merged;
  overlay_pixel_pkg::vga_rgb_t next_vga;

  // camera regions never overlap, an idle channel outputs black,
  // so a plain or of all channels picks the active one
  always_comb begin
    merged = overlay_pixel_pkg::black;
    for (int c = 0; c < overlay_geom_pkg::num_cams; c++) begin
      merged = merged | color[c];
    end
  end

  // nothing is driven during blanking
  assign next_vga = visible ? merged : overlay_pixel_pkg::black;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      vga <= overlay_pixel_pkg::black;
    end else begin
      vga <= next_vga;
    end
  end

endmodule

//--- verilog/camera_overlay.sv
module camera_overlay (
  input  logic                                 rst,  // pixel clock
  input  logic                                 clk,  // async reset, active high
  input  overlay_geom_pkg::cam_view_t          view,
  input  overlay_pixel_pkg::cam_status_t       status,
  input  overlay_pixel_pkg::buf_pixel_t        frame_pixel,
  input  logic                                 rgbmode,
  input  logic                                 new_pxl,
  output logic [overlay_geom_pkg::addr_w-1:0]  frame_addr,
  output overlay_pixel_pkg::vga_rgb_t          color
);

  overlay_pixel_pkg::vga_rgb_t image_color;
  overlay_pixel_pkg::vga_rgb_t filter_color;
  logic [overlay_pixel_pkg::prox_w-1:0] prox_inv;
  logic [2:0]                           seg_idx;
  logic                                 prox_on;
  logic                                 centroid_on;
  logic                                 addr_step;

  // read address steps once per pixel through the image

  assign addr_step = (view.region == overlay_geom_pkg::region_image) && new_pxl;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frame_addr <= '0;
    end else if (!view.in_img_rows) begin
      frame_addr <= '0;  // restart for the next frame
    end else if (addr_step) begin
      frame_addr <= frame_addr + 1'b1;
    end
  end

  // frame_pixel belongs to the current address
  always_comb begin
    if (rgbmode) begin
      image_color.red   = frame_pixel.red;
      image_color.green = frame_pixel.green;
      image_color.blue  = frame_pixel.blue;
    end else begin
      // grey value taken from bits 7:4 of the word
      image_color.red   = frame_pixel[7:4];
      image_color.green = frame_pixel[7:4];
      image_color.blue  = frame_pixel[7:4];
    end
  end

  // filter bits expanded to full intensity
  assign filter_color.red   = {overlay_pixel_pkg::chan_w{status.rgbfilter[2]}};
  assign filter_color.green = {overlay_pixel_pkg::chan_w{status.rgbfilter[1]}};
  assign filter_color.blue  = {overlay_pixel_pkg::chan_w{status.rgbfilter[0]}};

  // vertical bar grows towards the top as the object gets closer
  // proximity 7 lights every band, proximity 0 only the lowest one
  assign prox_inv = ~status.proximity;
  assign prox_on  = prox_inv <= view.row_band;

  // one centroid bit per 20 column segment with bit 0 on the left
  assign seg_idx = 3'(view.local_col / overlay_geom_pkg::centroid_seg_cols);
  assign centroid_on = status.centroid[seg_idx];

  always_comb begin
    color = overlay_pixel_pkg::black;
    case (view.region)
      overlay_geom_pkg::region_image: begin
        color = image_color;
      end
      overlay_geom_pkg::region_proximity: begin
        if (prox_on) begin
          color = filter_color;
        end
      end
      overlay_geom_pkg::region_centroid: begin
        if (centroid_on) begin
          color = filter_color;
        end
      end
      overlay_geom_pkg::region_filterbox: begin
        color = filter_color;  // shows which colour is being tracked
      end
      default: begin
        color = overlay_pixel_pkg::black;
      end
    endcase
  end

endmodule

//--- verilog/screen_region_decoder.sv
module screen_region_decoder (
  input  logic [overlay_geom_pkg::pos_w-1:0] col,
  input  logic [overlay_geom_pkg::pos_w-1:0] row,
  output overlay_geom_pkg::cam_view_t [overlay_geom_pkg::num_cams-1:0] view
);

  // row bands are common to both cameras
  logic in_img;
  logic in_centroid;
  logic in_fbox;

  assign in_img = row < overlay_geom_pkg::img_rows;

  assign in_centroid = (row >= overlay_geom_pkg::img_rows) &&
                       (row < overlay_geom_pkg::img_rows + overlay_geom_pkg::centroid_rows);

  assign in_fbox = (row >= overlay_geom_pkg::fbox_row_min) &&
                   (row < overlay_geom_pkg::fbox_row_min + overlay_geom_pkg::fbox_rows);

  for (genvar c = 0; c < overlay_geom_pkg::num_cams; c++) begin : g_cam
    logic [overlay_geom_pkg::pos_w-1:0] rel_col;
    logic                               in_img_cols;
    logic                               in_prox_cols;
    logic                               in_fbox_cols;
    overlay_geom_pkg::cam_view_t        cam_view;

    // left of the origin the difference wraps to a large value, so a
    // single unsigned compare covers both ends of the image
    assign rel_col = col - overlay_geom_pkg::cam_col_origin[c];

    assign in_img_cols = rel_col < overlay_geom_pkg::img_cols;

    assign in_prox_cols = (rel_col >= overlay_geom_pkg::img_cols) &&
                          (rel_col < overlay_geom_pkg::img_cols + overlay_geom_pkg::prox_cols);

    // box position is absolute and the left box sits inside the left image columns
    assign in_fbox_cols = (col >= overlay_geom_pkg::fbox_col_origin[c]) &&
                          (col < overlay_geom_pkg::fbox_col_origin[c] +
                                 overlay_geom_pkg::fbox_cols);

    always_comb begin
      if (in_img && in_img_cols) begin
        cam_view.region = overlay_geom_pkg::region_image;
      end else if (in_img && in_prox_cols) begin
        cam_view.region = overlay_geom_pkg::region_proximity;
      end else if (in_centroid && in_img_cols) begin
        cam_view.region = overlay_geom_pkg::region_centroid;
      end else if (in_fbox && in_fbox_cols) begin
        cam_view.region = overlay_geom_pkg::region_filterbox;
      end else begin
        cam_view.region = overlay_geom_pkg::region_none;
      end
      cam_view.local_col   = rel_col[overlay_geom_pkg::local_col_w-1:0];
      cam_view.row_band    = row[6:4];  // 8 bands of 16 rows
      cam_view.in_img_rows = in_img;
    end

    assign view[c] = cam_view;
  end

endmodule

//--- verilog/overlay_pixel_pkg.sv
package overlay_pixel_pkg;

  localparam int chan_w = 4;      // bits per colour channel
  localparam int filter_w = 3;    // one bit each for red, green, blue
  localparam int centroid_w = 8;  // one bit per strip segment
  localparam int prox_w = 3;

  // 4-4-4 word as stored in the frame buffer
  typedef struct packed {
    logic [chan_w-1:0] red;    // bits 11:8
    logic [chan_w-1:0] green;  // bits 7:4
    logic [chan_w-1:0] blue;   // bits 3:0
  } buf_pixel_t;

  // colour sent to the vga dac
  typedef struct packed {
    logic [chan_w-1:0] red;
    logic [chan_w-1:0] green;
    logic [chan_w-1:0] blue;
  } vga_rgb_t;

  // status coming from the image processing of one camera
  typedef struct packed {
    logic [filter_w-1:0]   rgbfilter;  // 2 red, 1 green, 0 blue
    logic [centroid_w-1:0] centroid;
    logic [prox_w-1:0]     proximity;  // 7 is closest
  } cam_status_t;

  localparam vga_rgb_t black = '0;

endpackage

//--- verilog/overlay_geom_pkg.sv
package overlay_geom_pkg;

  localparam int num_cams = 2;  // 0 left, 1 right
  localparam int addr_w = 15;   // 160*120 pixels fit in 2^15
  localparam int pos_w = 10;
  localparam int local_col_w = 8;
  localparam int row_band_w = 3;

  // qqvga image size
  localparam logic [pos_w-1:0] img_cols = 10'd160;
  localparam logic [pos_w-1:0] img_rows = 10'd120;

  // first column of each camera image with index 0 on the left
  localparam logic [num_cams-1:0][pos_w-1:0] cam_col_origin = {10'd256, 10'd0};

  localparam logic [pos_w-1:0] prox_cols = 10'd8;          // bar right of each image
  localparam logic [pos_w-1:0] centroid_rows = 10'd8;      // strip under each image
  localparam logic [pos_w-1:0] centroid_seg_cols = 10'd20; // 8 segments over 160 columns

  // filter colour boxes share one band of rows
  localparam logic [pos_w-1:0] fbox_row_min = 10'd128;
  localparam logic [pos_w-1:0] fbox_rows = 10'd8;
  localparam logic [num_cams-1:0][pos_w-1:0] fbox_col_origin = {10'd256, 10'd24};
  localparam logic [pos_w-1:0] fbox_cols = 10'd8;

  // what one camera channel draws at the current pixel
  typedef enum logic [2:0] {
    region_none,
    region_image,
    region_proximity,
    region_centroid,
    region_filterbox
  } region_e;

  typedef struct packed {
    region_e                region;
    logic [local_col_w-1:0] local_col;   // column relative to the camera origin
    logic [row_band_w-1:0]  row_band;    // row bits 6:4 for the proximity bar
    logic                   in_img_rows;
  } cam_view_t;

endpackage
